/* pla_loop_vectors.txt */
# mode interval link_mask frames frame_len
# mode 0 bypass, 1 external, 2 internal; interval and link_mask in hex
0 ffff ffffff 20 16
1 0040 a5f0c3 0 0
1 0100 000000 0 0
2 ffff ffffff 12 16
2 ffff 3c3c3c 8 64
1 0020 f0f0f0 16 24
1 0010 0f0f0f 10 40
2 0030 ffffff 10 20

/* verilog.f */
+incdir+.
xgmii_pkg.sv
loop_pkg.sv
loop_request_gen.sv
loop_mac_swap.sv
loop_merge_arb.sv
pla_loop_set.sv
tb_clk_gen.sv
tb_pla_loop_set.sv

/* Makefile */
# Verilator build and run for the loop and request source testbench

VERILATOR ?= verilator
TOP       ?= tb_pla_loop_set
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_pla_loop_set.sv */
/* Loop and request source testbench
   Vector-driven stimulus with a reference model for request and loop frames */
`timescale 1ns/1ps
`include "pla_loop_macros.svh"

module tb_pla_loop_set;

    localparam xgmii_pkg::xgmii_word_t IDLE_F = '{data: `PLA_IDLE_WORD, ctrl: 4'hf};

    logic                       clk;
    logic                       gen_rst;
    logic                       test_rst;
    loop_pkg::loop_mode_e       loop_en;
    logic [`PLA_LINK_NUM-1:0]   loop_link;
    loop_pkg::air_mac_tbl_t     air_mac;
    loop_pkg::rcu_mac_tbl_t     rcu_req_mac;
    logic [15:0]                request_ifg;
    xgmii_pkg::xgmii_word_t     back_air;
    xgmii_pkg::xgmii_word_t     fwd_air;
    xgmii_pkg::xgmii_word_t     loop_out;
    logic                       overflow;

    integer                     seed = 32'haac8f3f5;
    int                         cycles = 0;
    int                         cycle_limit = 0;
    int                         req_seen;
    logic                       collect_en = 1'b0;
    logic                       in_frame;
    logic                       after_term;
    xgmii_pkg::xgmii_word_t     cur_q[$];
    xgmii_pkg::xgmii_word_t     exp_words[$];
    int                         exp_lens[$];

    tb_clk_gen tb_clk_gen_i (
        .clk (clk),
        .rst (gen_rst)
    );

    pla_loop_set pla_loop_set_i (
        .I_pla_312m5_clk (clk),
        .I_pla_rst       (gen_rst | test_rst),
        .loop_en         (loop_en),
        .loop_link       (loop_link),
        .air_mac         (air_mac),
        .rcu_req_mac     (rcu_req_mac),
        .request_ifg     (request_ifg),
        .back_air        (back_air),
        .fwd_air         (fwd_air),
        .loop_out        (loop_out),
        .overflow        (overflow)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input xgmii_pkg::xgmii_word_t got,
                              input xgmii_pkg::xgmii_word_t exp);
        assert (got === exp)
        else
            fail_run($sformatf("mismatch at %0d ns: %s got %h expected %h",
                               $time, name, got, exp));
    endtask

    // Request frame word from the 19-word frame layout
    function automatic xgmii_pkg::xgmii_word_t req_word_exp(input int link, input int idx);
        xgmii_pkg::xgmii_word_t w;
        logic [47:0]            rcu;
        logic [47:0]            air;
        rcu = rcu_req_mac[link / `PLA_LINKS_PER_GRP];
        air = air_mac[link];
        w   = '{data: 32'd0, ctrl: 4'h0};
        case (idx)
            0:  w = '{data: `PLA_START_WORD, ctrl: 4'h8};
            1:  w.data = `PLA_SFD_WORD;
            2:  w.data = rcu[47:16];
            3:  w.data = {rcu[15:0], air[47:32]};
            4:  w.data = air[31:0];
            5:  w.data = {`PLA_REQ_TAG, 1'b1, ~loop_link[link], 14'd0};
            6:  w.data = {12'd0, `PLA_ACM_MODE, 16'd0};
            8:  w.data = `PLA_RMU_REQUEST;
            9:  w.data = {`PLA_RMU_RATE, 16'd0};
            18: w = '{data: `PLA_TERM_WORD, ctrl: 4'hf};
            default: w.data = 32'd0;
        endcase
        return w;
    endfunction

    // Only request frames carry the tag in word 5
    task automatic process_frame();
        int link;
        int len;
        if (cur_q.size() == `PLA_REQ_FRAME_LEN && cur_q[5].ctrl == 4'h0 &&
            cur_q[5].data[31:16] == `PLA_REQ_TAG)
        begin
            link = req_seen % `PLA_LINK_NUM;
            for (int i = 0; i < `PLA_REQ_FRAME_LEN; i++)
                check_word($sformatf("loop_out request link %0d word %0d", link, i),
                           cur_q[i], req_word_exp(link, i));
            req_seen++;
        end
        else
        begin
            assert (exp_lens.size() > 0)
            else
                fail_run("a loop frame came out that was never sent");
            len = exp_lens.pop_front();
            assert (cur_q.size() == len)
            else
                fail_run($sformatf("mismatch at %0d ns: loop frame length got %0d expected %0d",
                                   $time, cur_q.size(), len));
            for (int i = 0; i < len; i++)
                check_word($sformatf("loop_out loop word %0d", i), cur_q[i],
                           exp_words.pop_front());
        end
    endtask

    //------------------------------------------------------------------------
    // Output frame collector
    //------------------------------------------------------------------------
    always @(negedge clk)
    begin
        if (!collect_en)
        begin
            in_frame   = 1'b0;
            after_term = 1'b0;
        end
        else if (!in_frame)
        begin
            if (loop_out.ctrl == 4'h8 && loop_out.data == `PLA_START_WORD)
            begin
                assert (!after_term)
                else
                    fail_run("a frame started with no idle after the previous frame");
                in_frame = 1'b1;
                cur_q    = {loop_out};
            end
            else
            begin
                check_word("loop_out between frames", loop_out, IDLE_F);
                after_term = 1'b0;
            end
        end
        else
        begin
            assert (!(loop_out.ctrl == 4'h8 && loop_out.data == `PLA_START_WORD))
            else
                fail_run("a start word appeared inside a frame, frames interleaved");
            cur_q.push_back(loop_out);
            if (loop_out.ctrl == 4'hf && loop_out.data == `PLA_TERM_WORD)
            begin
                process_frame();
                in_frame   = 1'b0;
                after_term = 1'b1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
            fail_run("timeout, the run went past its cycle limit");
    end

    task automatic run_bypass(input int n);
        xgmii_pkg::xgmii_word_t prev;
        logic [31:0]            r;
        prev = back_air;
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            check_word("loop_out bypass", loop_out, prev);
            r             = $random(seed);
            back_air.data = $random(seed);
            back_air.ctrl = r[3:0];
            prev          = back_air;
        end
    endtask

    // Loop frames with random MACs and payload, each followed by idles
    task automatic send_loop_frames(input int mode, input int n, input int len);
        xgmii_pkg::xgmii_word_t w[$];
        logic [63:0]            da;
        logic [63:0]            sa;
        logic [31:0]            r;
        for (int f = 0; f < n; f++)
        begin
            da = {$random(seed), $random(seed)};
            sa = {$random(seed), $random(seed)};
            w  = {};
            w.push_back('{data: `PLA_START_WORD, ctrl: 4'h8});
            w.push_back('{data: `PLA_SFD_WORD, ctrl: 4'h0});
            w.push_back('{data: da[47:16], ctrl: 4'h0});
            w.push_back('{data: {da[15:0], sa[47:32]}, ctrl: 4'h0});
            w.push_back('{data: sa[31:0], ctrl: 4'h0});
            for (int i = 5; i < len - 1; i++)
            begin
                r = $random(seed);
                if (i == 5)
                    r[31] = 1'b0;
                w.push_back('{data: r, ctrl: 4'h0});
            end
            w.push_back('{data: `PLA_TERM_WORD, ctrl: 4'hf});
            for (int i = 0; i < len; i++)
                exp_words.push_back(w[i]);
            // Internal loop returns the frame with DA and SA exchanged
            if (mode == 2)
            begin
                exp_words[exp_words.size() - len + 2].data = sa[47:16];
                exp_words[exp_words.size() - len + 3].data = {sa[15:0], da[47:32]};
                exp_words[exp_words.size() - len + 4].data = da[31:0];
            end
            exp_lens.push_back(len);
            for (int i = 0; i < len; i++)
            begin
                @(negedge clk);
                if (mode == 2)
                    fwd_air = w[i];
                else
                    back_air = w[i];
            end
            r = $random(seed);
            for (int i = 0; i < 22 + int'(r[1:0]); i++)
            begin
                @(negedge clk);
                fwd_air  = IDLE_F;
                back_air = IDLE_F;
            end
        end
    endtask

    task automatic run_test(input int mode, input int ifg, input int mask,
                            input int frames, input int len);
        logic [63:0] m;
        collect_en = 1'b0;
        @(negedge clk);
        test_rst    = 1'b1;
        loop_en     = loop_pkg::loop_mode_e'(mode[1:0]);
        request_ifg = 16'(ifg);
        loop_link   = 24'(mask);
        back_air    = IDLE_F;
        fwd_air     = IDLE_F;
        for (int i = 0; i < `PLA_LINK_NUM; i++)
        begin
            m          = {$random(seed), $random(seed)};
            air_mac[i] = m[47:0];
        end
        for (int i = 0; i < `PLA_LINK_NUM / `PLA_LINKS_PER_GRP; i++)
        begin
            m              = {$random(seed), $random(seed)};
            rcu_req_mac[i] = m[47:0];
        end
        repeat (3) @(negedge clk);
        test_rst = 1'b0;
        @(negedge clk);
        check_word("loop_out after reset", loop_out, IDLE_F);
        assert (overflow === 1'b0)
        else
            fail_run($sformatf("mismatch at %0d ns: overflow got %b expected 0",
                               $time, overflow));
        req_seen = 0;
        if (mode == 0)
            run_bypass(frames * len);
        else
        begin
            collect_en = 1'b1;
            send_loop_frames(mode, frames, len);
            while (exp_lens.size() != 0 || (frames == 0 && req_seen < `PLA_LINK_NUM))
                @(negedge clk);
            assert (overflow === 1'b0)
            else
                fail_run($sformatf("mismatch at %0d ns: overflow got %b expected 0",
                                   $time, overflow));
        end
    endtask

    //------------------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------------------
    initial
    begin
        int    fd;
        int    code;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        int    v_mode[$];
        int    v_ifg[$];
        int    v_mask[$];
        int    v_frames[$];
        int    v_len[$];
        string line;
        loop_en     = loop_pkg::LOOP_BYPASS;
        loop_link   = '0;
        air_mac     = '0;
        rcu_req_mac = '0;
        request_ifg = 16'hffff;
        back_air    = IDLE_F;
        fwd_air     = IDLE_F;
        test_rst    = 1'b0;

        fd = $fopen("pla_loop_vectors.txt", "r");
        assert (fd != 0)
        else
            fail_run("cannot open the vectors file pla_loop_vectors.txt");
        while (!$feof(fd))
        begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line.getc(0) != 8'h23 &&
                $sscanf(line, "%d %h %h %d %d", a, b, c, d, e) == 5)
            begin
                v_mode.push_back(a);
                v_ifg.push_back(b);
                v_mask.push_back(c);
                v_frames.push_back(d);
                v_len.push_back(e);
            end
        end
        $fclose(fd);

        // Frames with gaps, one burst of requests and the interval per test
        for (int t = 0; t < v_mode.size(); t++)
            cycle_limit += v_frames[t] * (v_len[t] + 50) + v_ifg[t] +
                           `PLA_LINK_NUM * (`PLA_REQ_FRAME_LEN + 3) + 100;
        cycle_limit *= 2;

        while (gen_rst)
            @(negedge clk);
        for (int t = 0; t < v_mode.size(); t++)
            run_test(v_mode[t], v_ifg[t], v_mask[t], v_frames[t], v_len[t]);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
/* Testbench clock and power-on reset
   8 ns clock, reset held for the first three cycles */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    always #4 clk = ~clk;

endmodule

/* pla_loop_set.sv */
/* PLA loopback and request source top
   Picks the loop stream by mode and registers the merged or bypassed lane */
`timescale 1ns/1ps
`include "pla_loop_macros.svh"

module pla_loop_set (
    input  logic                        I_pla_312m5_clk,
    input  logic                        I_pla_rst,
    input  loop_pkg::loop_mode_e        loop_en,
    input  logic [`PLA_LINK_NUM-1:0]    loop_link,
    input  loop_pkg::air_mac_tbl_t      air_mac,
    input  loop_pkg::rcu_mac_tbl_t      rcu_req_mac,
    input  logic [15:0]                 request_ifg,
    input  xgmii_pkg::xgmii_word_t      back_air,
    input  xgmii_pkg::xgmii_word_t      fwd_air,
    output xgmii_pkg::xgmii_word_t      loop_out,
    output logic                        overflow
);

    xgmii_pkg::xgmii_word_t swap_out;
    xgmii_pkg::xgmii_word_t loop_src;
    xgmii_pkg::xgmii_word_t req_word;
    xgmii_pkg::xgmii_word_t merge_out;
    logic                   req_pending;
    logic                   req_last;
    logic                   req_grant;

    loop_request_gen loop_request_gen_i (
        .I_pla_312m5_clk (I_pla_312m5_clk),
        .I_pla_rst       (I_pla_rst),
        .request_ifg     (request_ifg),
        .loop_link       (loop_link),
        .air_mac         (air_mac),
        .rcu_req_mac     (rcu_req_mac),
        .req_grant       (req_grant),
        .req_pending     (req_pending),
        .req_word        (req_word),
        .req_last        (req_last)
    );

    loop_mac_swap loop_mac_swap_i (
        .I_pla_312m5_clk (I_pla_312m5_clk),
        .I_pla_rst       (I_pla_rst),
        .fwd_in          (fwd_air),
        .fwd_out         (swap_out)
    );

    // External loop already has swapped MACs, internal loop swaps here
    assign loop_src = (loop_en == loop_pkg::LOOP_INT) ? swap_out : back_air;

    loop_merge_arb loop_merge_arb_i (
        .I_pla_312m5_clk (I_pla_312m5_clk),
        .I_pla_rst       (I_pla_rst),
        .loop_in         (loop_src),
        .req_pending     (req_pending),
        .req_word        (req_word),
        .req_last        (req_last),
        .req_grant       (req_grant),
        .merge_out       (merge_out),
        .overflow        (overflow)
    );

    // Output register
    always_ff @(posedge I_pla_312m5_clk or posedge I_pla_rst)
    begin
        if (I_pla_rst)
            loop_out <= '{data: `PLA_IDLE_WORD, ctrl: {`PLA_CTRL_W{1'b1}}};
        else if (loop_en == loop_pkg::LOOP_BYPASS)
            loop_out <= back_air;
        else
            loop_out <= merge_out;
    end

endmodule

/* loop_merge_arb.sv */
/* Loop and request merge
   Buffers loop frames and shares the output lane at frame boundaries */
`timescale 1ns/1ps
`include "pla_loop_macros.svh"

module loop_merge_arb (
    input  logic                    I_pla_312m5_clk,
    input  logic                    I_pla_rst,
    input  xgmii_pkg::xgmii_word_t  loop_in,
    input  logic                    req_pending,
    input  xgmii_pkg::xgmii_word_t  req_word,
    input  logic                    req_last,
    output logic                    req_grant,
    output xgmii_pkg::xgmii_word_t  merge_out,
    output logic                    overflow
);

    localparam int AW = $clog2(`PLA_LOOP_FIFO_DEPTH);

    xgmii_pkg::xgmii_word_t fifo_mem [`PLA_LOOP_FIFO_DEPTH];
    xgmii_pkg::xgmii_word_t fifo_head;
    xgmii_pkg::xgmii_kind_e in_kind;
    xgmii_pkg::xgmii_kind_e head_kind;
    loop_pkg::arb_state_e   state;
    logic [AW:0]            wr_ptr;
    logic [AW:0]            rd_ptr;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   in_frame;
    logic                   accept;
    logic                   fifo_wr;
    logic                   fifo_rd;
    logic                   req_turn;

    //------------------------------------------------------------------------
    // Loop FIFO, frame words only
    //------------------------------------------------------------------------
    assign in_kind    = xgmii_pkg::xgmii_kind(loop_in);
    assign accept     = (in_kind == xgmii_pkg::XGMII_START) ||
                        (in_frame && in_kind != xgmii_pkg::XGMII_IDLE);
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign fifo_wr    = accept && !fifo_full;
    assign fifo_rd    = (state == loop_pkg::ARB_LOOP) && !fifo_empty;
    assign fifo_head  = fifo_mem[rd_ptr[AW-1:0]];
    assign head_kind  = xgmii_pkg::xgmii_kind(fifo_head);

    always_ff @(posedge I_pla_312m5_clk)
    begin
        if (fifo_wr)
            fifo_mem[wr_ptr[AW-1:0]] <= loop_in;
    end

    // Source cannot stall, so a full FIFO drops and flags it
    always_ff @(posedge I_pla_312m5_clk or posedge I_pla_rst)
    begin
        if (I_pla_rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            in_frame <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            if (in_kind == xgmii_pkg::XGMII_START)
                in_frame <= 1'b1;
            else if (in_kind != xgmii_pkg::XGMII_DATA)
                in_frame <= 1'b0;
            if (fifo_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (fifo_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (accept && fifo_full)
                overflow <= 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Arbiter, alternates sources when both are waiting
    //------------------------------------------------------------------------
    always_ff @(posedge I_pla_312m5_clk or posedge I_pla_rst)
    begin
        if (I_pla_rst)
        begin
            state     <= loop_pkg::ARB_GAP;
            req_turn  <= 1'b0;
            merge_out <= '{data: `PLA_IDLE_WORD, ctrl: {`PLA_CTRL_W{1'b1}}};
        end
        else
        begin
            case (state)
                loop_pkg::ARB_GAP:
                begin
                    merge_out <= '{data: `PLA_IDLE_WORD, ctrl: {`PLA_CTRL_W{1'b1}}};
                    if (req_pending && (fifo_empty || req_turn))
                        state <= loop_pkg::ARB_REQ;
                    else if (!fifo_empty)
                        state <= loop_pkg::ARB_LOOP;
                end
                loop_pkg::ARB_LOOP:
                begin
                    // Empty only after a drop broke the frame
                    if (fifo_empty)
                        merge_out <= '{data: `PLA_IDLE_WORD, ctrl: {`PLA_CTRL_W{1'b1}}};
                    else
                    begin
                        merge_out <= fifo_head;
                        if (head_kind == xgmii_pkg::XGMII_TERM)
                        begin
                            state    <= loop_pkg::ARB_GAP;
                            req_turn <= 1'b1;
                        end
                    end
                end
                loop_pkg::ARB_REQ:
                begin
                    merge_out <= req_word;
                    if (req_last)
                    begin
                        state    <= loop_pkg::ARB_GAP;
                        req_turn <= 1'b0;
                    end
                end
                default: state <= loop_pkg::ARB_GAP;
            endcase
        end
    end

    assign req_grant = (state == loop_pkg::ARB_REQ);

endmodule

/* loop_mac_swap.sv */
/* Forward stream MAC swap
   Three-stage delay line that exchanges DA and SA of every frame */
`timescale 1ns/1ps
`include "pla_loop_macros.svh"

module loop_mac_swap (
    input  logic                    I_pla_312m5_clk,
    input  logic                    I_pla_rst,
    input  xgmii_pkg::xgmii_word_t  fwd_in,
    output xgmii_pkg::xgmii_word_t  fwd_out
);

    localparam int HALF = `PLA_DATA_W / 2;

    xgmii_pkg::xgmii_word_t s1;
    xgmii_pkg::xgmii_word_t s2;
    xgmii_pkg::xgmii_word_t s3;
    xgmii_pkg::xgmii_kind_e in_kind;
    logic [2:0]             word_cnt;
    logic [2:0]             in_idx;
    logic                   do_swap;

    assign in_kind = xgmii_pkg::xgmii_kind(fwd_in);

    // Index of the word now at the input, start is always word 0
    assign in_idx  = (in_kind == xgmii_pkg::XGMII_START) ? 3'd0 : word_cnt;

    // Word 4 at the input: words 3 and 2 sit in s1 and s2
    assign do_swap = (in_idx == 3'd4) && (in_kind == xgmii_pkg::XGMII_DATA);

    // Counts frame words, saturates past the address words
    always_ff @(posedge I_pla_312m5_clk or posedge I_pla_rst)
    begin
        if (I_pla_rst)
            word_cnt <= '0;
        else if (in_kind == xgmii_pkg::XGMII_IDLE)
            word_cnt <= '0;
        else if (in_idx != 3'd7)
            word_cnt <= in_idx + 3'd1;
    end

    // All three address words are rewritten on one edge, then shift as is
    always_ff @(posedge I_pla_312m5_clk or posedge I_pla_rst)
    begin
        if (I_pla_rst)
        begin
            s1 <= '{data: `PLA_IDLE_WORD, ctrl: {`PLA_CTRL_W{1'b1}}};
            s2 <= '{data: `PLA_IDLE_WORD, ctrl: {`PLA_CTRL_W{1'b1}}};
            s3 <= '{data: `PLA_IDLE_WORD, ctrl: {`PLA_CTRL_W{1'b1}}};
        end
        else if (do_swap)
        begin
            // SA upper
            s3.data <= {s1.data[HALF-1:0], fwd_in.data[`PLA_DATA_W-1:HALF]};
            s3.ctrl <= s2.ctrl;
            // SA lower, DA upper
            s2.data <= {fwd_in.data[HALF-1:0], s2.data[`PLA_DATA_W-1:HALF]};
            s2.ctrl <= s1.ctrl;
            // DA lower
            s1.data <= {s2.data[HALF-1:0], s1.data[`PLA_DATA_W-1:HALF]};
            s1.ctrl <= fwd_in.ctrl;
        end
        else
        begin
            s1 <= fwd_in;
            s2 <= s1;
            s3 <= s2;
        end
    end

    assign fwd_out = s3;

endmodule

/* loop_request_gen.sv */
/* Request frame generator
   Interval timer starts a burst of one request frame per air link */
`timescale 1ns/1ps
`include "pla_loop_macros.svh"

module loop_request_gen (
    input  logic                        I_pla_312m5_clk,
    input  logic                        I_pla_rst,
    input  logic [15:0]                 request_ifg,
    input  logic [`PLA_LINK_NUM-1:0]    loop_link,
    input  loop_pkg::air_mac_tbl_t      air_mac,
    input  loop_pkg::rcu_mac_tbl_t      rcu_req_mac,
    input  logic                        req_grant,
    output logic                        req_pending,
    output xgmii_pkg::xgmii_word_t      req_word,
    output logic                        req_last
);

    localparam int LINK_W = $clog2(`PLA_LINK_NUM);
    localparam int GRP_W  = $clog2(`PLA_LINK_NUM / `PLA_LINKS_PER_GRP);
    localparam int WORD_W = $clog2(`PLA_REQ_FRAME_LEN);

    loop_pkg::req_state_e   state;
    logic [15:0]            ifg_cnt;
    logic                   ifg_fire;
    logic                   burst_busy;
    logic [LINK_W-1:0]      link_idx;
    logic [GRP_W-1:0]       grp_idx;
    logic [WORD_W-1:0]      word_cnt;
    logic [`PLA_MAC_W-1:0]  cur_air_mac;
    logic [`PLA_MAC_W-1:0]  cur_rcu_mac;
    logic                   cur_link_up;

    //------------------------------------------------------------------------
    // Interval timer and burst sequencing
    //------------------------------------------------------------------------
    assign ifg_fire = (ifg_cnt == request_ifg);

    always_ff @(posedge I_pla_312m5_clk or posedge I_pla_rst)
    begin
        if (I_pla_rst)
            ifg_cnt <= '0;
        else if (ifg_fire)
            ifg_cnt <= '0;
        else
            ifg_cnt <= ifg_cnt + 16'd1;
    end

    // IDLE between frames keeps pending low for a cycle after the last word
    always_ff @(posedge I_pla_312m5_clk or posedge I_pla_rst)
    begin
        if (I_pla_rst)
        begin
            state      <= loop_pkg::REQ_IDLE;
            burst_busy <= 1'b0;
            link_idx   <= '0;
            word_cnt   <= '0;
        end
        else
        begin
            case (state)
                loop_pkg::REQ_IDLE:
                begin
                    if (burst_busy)
                        state <= loop_pkg::REQ_WAIT;
                    else if (ifg_fire)
                    begin
                        burst_busy <= 1'b1;
                        link_idx   <= '0;
                        state      <= loop_pkg::REQ_WAIT;
                    end
                end
                // Word 0 goes out in the first granted cycle
                loop_pkg::REQ_WAIT:
                begin
                    if (req_grant)
                    begin
                        word_cnt <= WORD_W'(1);
                        state    <= loop_pkg::REQ_SEND;
                    end
                end
                loop_pkg::REQ_SEND:
                begin
                    if (req_last)
                    begin
                        word_cnt <= '0;
                        state    <= loop_pkg::REQ_IDLE;
                        if (link_idx == LINK_W'(`PLA_LINK_NUM - 1))
                            burst_busy <= 1'b0;
                        else
                            link_idx <= link_idx + 1'b1;
                    end
                    else
                        word_cnt <= word_cnt + 1'b1;
                end
                default: state <= loop_pkg::REQ_IDLE;
            endcase
        end
    end

    assign req_pending = (state == loop_pkg::REQ_WAIT);
    assign req_last    = (state == loop_pkg::REQ_SEND) &&
                         (word_cnt == WORD_W'(`PLA_REQ_FRAME_LEN - 1));

    //------------------------------------------------------------------------
    // Frame words for the current link
    //------------------------------------------------------------------------
    assign grp_idx     = GRP_W'(link_idx / `PLA_LINKS_PER_GRP);
    assign cur_air_mac = air_mac[link_idx];
    assign cur_rcu_mac = rcu_req_mac[grp_idx];
    assign cur_link_up = loop_link[link_idx];

    always_comb
    begin
        req_word.ctrl = '0;
        case (word_cnt)
            'd0:
            begin
                req_word.data = `PLA_START_WORD;
                req_word.ctrl = 4'h8;
            end
            'd1:     req_word.data = `PLA_SFD_WORD;
            'd2:     req_word.data = cur_rcu_mac[47:16];
            'd3:     req_word.data = {cur_rcu_mac[15:0], cur_air_mac[47:32]};
            'd4:     req_word.data = cur_air_mac[31:0];
            // New-set always 1, link-down flag below it
            'd5:     req_word.data = {`PLA_REQ_TAG, 1'b1, ~cur_link_up, 14'd0};
            'd6:     req_word.data = {12'd0, `PLA_ACM_MODE, 16'd0};
            'd8:     req_word.data = `PLA_RMU_REQUEST;
            'd9:     req_word.data = {`PLA_RMU_RATE, 16'd0};
            'd18:
            begin
                req_word.data = `PLA_TERM_WORD;
                req_word.ctrl = 4'hf;
            end
            default: req_word.data = '0;
        endcase
    end

endmodule

/* loop_pkg.sv */
/* Loop block types
   Loop mode, per-link MAC tables and the FSM state encodings */
`include "pla_loop_macros.svh"

package loop_pkg;

    // Bit 0 external loop, bit 1 internal loop; both behaves as external
    typedef enum logic [1:0] {
        LOOP_BYPASS = 2'd0,
        LOOP_EXT    = 2'd1,
        LOOP_INT    = 2'd2,
        LOOP_BOTH   = 2'd3
    } loop_mode_e;

    // One air MAC per link
    typedef logic [`PLA_LINK_NUM-1:0][`PLA_MAC_W-1:0] air_mac_tbl_t;

    // One RCU request MAC per adapter group
    typedef logic [`PLA_LINK_NUM/`PLA_LINKS_PER_GRP-1:0][`PLA_MAC_W-1:0] rcu_mac_tbl_t;

    // Request generator
    typedef enum logic [1:0] {
        REQ_IDLE = 2'd0,
        REQ_WAIT = 2'd1,
        REQ_SEND = 2'd2
    } req_state_e;

    // Output lane arbiter
    typedef enum logic [1:0] {
        ARB_LOOP = 2'd0,
        ARB_GAP  = 2'd1,
        ARB_REQ  = 2'd2
    } arb_state_e;

endpackage

/* xgmii_pkg.sv */
/* XGMII lane types
   Lane word with its control nibble, and a classifier for word kinds */
`include "pla_loop_macros.svh"

package xgmii_pkg;

    typedef struct packed {
        logic [`PLA_DATA_W-1:0] data;
        logic [`PLA_CTRL_W-1:0] ctrl;
    } xgmii_word_t;

    typedef enum logic [1:0] {
        XGMII_IDLE  = 2'd0,
        XGMII_START = 2'd1,
        XGMII_DATA  = 2'd2,
        XGMII_TERM  = 2'd3
    } xgmii_kind_e;

    // Start only in lane 3, terminate in any lane
    function automatic xgmii_kind_e xgmii_kind(xgmii_word_t w);
        xgmii_kind_e k;
        k = XGMII_IDLE;
        if (w.ctrl == '0)
            k = XGMII_DATA;
        else if (w.ctrl[`PLA_CTRL_W-1] && w.data[`PLA_DATA_W-1 -: 8] == 8'hfb)
            k = XGMII_START;
        else
            for (int i = 0; i < `PLA_CTRL_W; i++)
                if (w.ctrl[i] && w.data[8*i +: 8] == 8'hfd)
                    k = XGMII_TERM;
        return k;
    endfunction

endpackage

/* pla_loop_macros.svh */
/* Loop and request-frame source constants
   Lane widths, link counts, frame sizes and fixed XGMII words */
`ifndef PLA_LOOP_MACROS_SVH
`define PLA_LOOP_MACROS_SVH

// XGMII lane, one 32-bit word per 312.5 MHz cycle
`define PLA_DATA_W          32
`define PLA_CTRL_W          4
`define PLA_MAC_W           48

// Air links, three adapter groups of eight
`define PLA_LINK_NUM        24
`define PLA_LINKS_PER_GRP   8

// Request frame is start, SFD, 16 body words and terminate
`define PLA_REQ_FRAME_LEN   19

// Loop buffer words
`define PLA_LOOP_FIFO_DEPTH 64

// Fixed lane words
`define PLA_IDLE_WORD       32'h07070707
`define PLA_START_WORD      32'hfb555555
`define PLA_SFD_WORD        32'h555555d5
`define PLA_TERM_WORD       32'hfd070707

// Request frame fields
`define PLA_REQ_TAG         16'h80fc
`define PLA_ACM_MODE        4'hf
`define PLA_RMU_REQUEST     32'd1289
`define PLA_RMU_RATE        16'd625

`endif
